// ==== include/sdram_params.svh ====
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// user address is {row, bank, column}
`define SDRAM_ROW_W   13
`define SDRAM_BANK_W  2
`define SDRAM_COL_W   13
`define SDRAM_ADDR_W  28

// command spacing counter
`define SDRAM_CNT_W   4

// refresh interval register, 0 disables refresh
`define SDRAM_REF_W   16

// A10 high on PRCH closes every bank
`define SDRAM_A10_BIT 10

`endif

// ==== hdl/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

	// commands seen on the SDRAM pins
	typedef enum logic [2:0] {
		NOOP = 3'd0,   // idle cycle
		ACTV = 3'd1,   // open a row
		READ = 3'd2,
		WRTE = 3'd3,
		PRCH = 3'd4,   // close page, A10 picks one or all banks
		ARSR = 3'd5    // auto refresh
	} sdram_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/refresh_cfg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_params.svh"

module refresh_cfg (
	input  wire                    CLK,
	input  wire                    RST,
	input  wire                    cfg_wr,
	input  wire [`SDRAM_REF_W-1:0] cfg_interval,
	output logic                   ref_toggle
);

	localparam logic [`SDRAM_REF_W-1:0] ONE = 1;

	logic [`SDRAM_REF_W-1:0] interval;   // 0 keeps refresh off
	logic [`SDRAM_REF_W-1:0] count;      // cycles left until next request
	logic                    enabled;
	logic                    expired;

	assign enabled = (interval != '0);
	assign expired = enabled && (count == '0);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			interval   <= '0;
			count      <= '0;
			ref_toggle <= 1'b0;
		end
		else if (cfg_wr)
		begin
			// a new interval restarts the count from the top
			interval <= cfg_interval;
			count    <= cfg_interval - ONE;
		end
		else if (expired)
		begin
			count      <= interval - ONE;
			ref_toggle <= ~ref_toggle;   // one flip per request
		end
		else if (enabled)
		begin
			count <= count - ONE;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bank_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_params.svh"

module bank_timer
	import sdram_pkg::*;
(
	input  wire             CLK,
	input  wire             RST,
	input  wire             issue_req,
	input  wire sdram_cmd_t next_cmd,
	output logic            issue_ok,
	output logic            page_open
);

	localparam int CW = `SDRAM_CNT_W;

	// counter runs from the start value up to CNT_DONE,
	// so the idle gap is CNT_DONE minus the start value
	localparam logic [CW-1:0] CNT_DONE   = '1;
	localparam logic [CW-1:0] START_ACTV = CW'(13);   // 2 idle
	localparam logic [CW-1:0] START_RW   = CW'(12);   // 3 idle
	localparam logic [CW-1:0] START_ARSR = CW'(0);    // 15 idle

	logic [CW-1:0] counter;
	sdram_cmd_t    last_cmd;
	logic          last_rw;
	logic          issue;

	// a repeated read or write may follow straight away
	assign issue_ok = (counter == CNT_DONE) ||
			(last_rw && (next_cmd == last_cmd));

	assign issue = issue_req && issue_ok;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			counter   <= CNT_DONE;
			last_cmd  <= NOOP;
			last_rw   <= 1'b0;
			page_open <= 1'b0;
		end
		else if (issue)
		begin
			last_cmd <= next_cmd;
			last_rw  <= (next_cmd == READ) || (next_cmd == WRTE);

			case (next_cmd)
				ACTV:
				begin
					counter   <= START_ACTV;
					page_open <= 1'b1;
				end
				PRCH:
				begin
					counter   <= START_RW;
					page_open <= 1'b0;   // page or all banks closed
				end
				ARSR:
				begin
					counter <= START_ARSR;
				end
				default:
				begin
					counter <= START_RW;
				end
			endcase
		end
		else if (counter != CNT_DONE)
		begin
			counter <= counter + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cmd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_params.svh"

module cmd_sequencer
	import sdram_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     req,
	input  wire [`SDRAM_ADDR_W-1:0] addr,
	input  wire                     we,
	input  wire                     ref_toggle,
	input  wire                     issue_ok,
	input  wire                     page_open,
	output logic                    ready,
	output logic                    issue_req,
	output sdram_cmd_t              next_cmd,
	output sdram_cmd_t              cmd,
	output logic [`SDRAM_BANK_W-1:0] ba,
	output logic [`SDRAM_ROW_W-1:0]  a
);

	// what goes on ba/a when an entry issues
	typedef enum logic [2:0] {
		SEL_NONE,   // refresh, pins zero
		SEL_PAGE,   // precharge one bank, A10 low
		SEL_ALL,    // precharge all, A10 high
		SEL_ROW,
		SEL_COL
	} addr_sel_t;

	localparam int DEPTH = 3;
	localparam logic [`SDRAM_ROW_W-1:0] A10_MASK = {{(`SDRAM_ROW_W-1){1'b0}}, 1'b1}
			<< `SDRAM_A10_BIT;

	sdram_cmd_t pend_cmd [DEPTH];
	addr_sel_t  pend_sel [DEPTH];
	logic [1:0] pend_cnt;
	logic       ref_ack;
	logic       ref_pending;
	logic       list_empty;
	logic       load_ref;
	logic       accept;
	logic       issue;
	logic       page_hit;
	sdram_cmd_t rw_cmd;

	logic [`SDRAM_ROW_W-1:0]  addr_row;
	logic [`SDRAM_BANK_W-1:0] addr_bank;
	logic [`SDRAM_COL_W-1:0]  addr_col;
	logic [`SDRAM_ROW_W-1:0]  req_row;
	logic [`SDRAM_BANK_W-1:0] req_bank;
	logic [`SDRAM_COL_W-1:0]  req_col;
	logic [`SDRAM_ROW_W-1:0]  open_row;
	logic [`SDRAM_BANK_W-1:0] open_bank;

	assign addr_row  = addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
	assign addr_bank = addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
	assign addr_col  = addr[`SDRAM_COL_W-1:0];

	assign ref_pending = ref_toggle ^ ref_ack;
	assign list_empty  = (pend_cnt == 2'd0);
	assign ready       = list_empty && !ref_pending;
	assign load_ref    = list_empty && ref_pending;   // refresh beats a new req
	assign accept      = req && ready;

	assign issue_req = !list_empty;
	assign next_cmd  = pend_cmd[0];
	assign issue     = issue_req && issue_ok;

	assign rw_cmd   = we ? WRTE : READ;
	assign page_hit = page_open && (addr_row == open_row) && (addr_bank == open_bank);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pend_cnt <= 2'd0;
			ref_ack  <= 1'b0;
			cmd      <= NOOP;
			for (int i = 0; i < DEPTH; i++)
			begin
				pend_cmd[i] <= NOOP;
				pend_sel[i] <= SEL_NONE;
			end
		end
		else
		begin
			cmd <= NOOP;   // commands last one cycle

			if (issue)
			begin
				cmd <= pend_cmd[0];
				for (int i = 0; i < DEPTH - 1; i++)
				begin
					pend_cmd[i] <= pend_cmd[i+1];
					pend_sel[i] <= pend_sel[i+1];
				end
				pend_cmd[DEPTH-1] <= NOOP;
				pend_sel[DEPTH-1] <= SEL_NONE;
				pend_cnt          <= pend_cnt - 2'd1;
			end
			else if (load_ref)
			begin
				ref_ack     <= ref_toggle;
				pend_cmd[0] <= PRCH;
				pend_sel[0] <= SEL_ALL;
				pend_cmd[1] <= ARSR;
				pend_sel[1] <= SEL_NONE;
				pend_cmd[2] <= NOOP;
				pend_sel[2] <= SEL_NONE;
				pend_cnt    <= 2'd2;
			end
			else if (accept)
			begin
				if (page_hit)
				begin
					pend_cmd[0] <= rw_cmd;
					pend_sel[0] <= SEL_COL;
					pend_cmd[1] <= NOOP;
					pend_sel[1] <= SEL_NONE;
					pend_cmd[2] <= NOOP;
					pend_sel[2] <= SEL_NONE;
					pend_cnt    <= 2'd1;
				end
				else
				begin
					pend_cmd[0] <= PRCH;
					pend_sel[0] <= SEL_PAGE;
					pend_cmd[1] <= ACTV;
					pend_sel[1] <= SEL_ROW;
					pend_cmd[2] <= rw_cmd;
					pend_sel[2] <= SEL_COL;
					pend_cnt    <= 2'd3;
				end
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			req_row  <= addr_row;
			req_bank <= addr_bank;
			req_col  <= addr_col;
		end

		if (issue)
		begin
			case (pend_sel[0])
				SEL_ROW:
				begin
					ba <= req_bank;
					a  <= req_row;
				end
				SEL_COL:
				begin
					ba <= req_bank;
					a  <= req_col;
				end
				SEL_PAGE:
				begin
					ba <= page_open ? open_bank : req_bank;   // close whatever is open
					a  <= '0;
				end
				SEL_ALL:
				begin
					ba <= '0;
					a  <= A10_MASK;
				end
				default:
				begin
					ba <= '0;
					a  <= '0;
				end
			endcase

			if (pend_cmd[0] == ACTV)
			begin
				open_row  <= req_row;
				open_bank <= req_bank;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sdram_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_params.svh"

module sdram_ctrl_top
	import sdram_pkg::*;
(
	input  wire                      CLK,
	input  wire                      RST,
	input  wire                      req,
	input  wire [`SDRAM_ADDR_W-1:0]  addr,
	input  wire                      we,
	input  wire                      cfg_wr,
	input  wire [`SDRAM_REF_W-1:0]   cfg_interval,
	output logic                     ready,
	output sdram_cmd_t               cmd,
	output logic [`SDRAM_BANK_W-1:0] ba,
	output logic [`SDRAM_ROW_W-1:0]  a
);

	wire        ref_toggle;
	wire        issue_req;
	wire        issue_ok;
	wire        page_open;
	sdram_cmd_t next_cmd;

	refresh_cfg refresh_cfg0 (
		.CLK          (CLK),
		.RST          (RST),
		.cfg_wr       (cfg_wr),
		.cfg_interval (cfg_interval),
		.ref_toggle   (ref_toggle)
	);

	bank_timer bank_timer0 (
		.CLK       (CLK),
		.RST       (RST),
		.issue_req (issue_req),
		.next_cmd  (next_cmd),
		.issue_ok  (issue_ok),
		.page_open (page_open)
	);

	cmd_sequencer cmd_sequencer0 (
		.CLK        (CLK),
		.RST        (RST),
		.req        (req),
		.addr       (addr),
		.we         (we),
		.ref_toggle (ref_toggle),
		.issue_ok   (issue_ok),
		.page_open  (page_open),
		.ready      (ready),
		.issue_req  (issue_req),
		.next_cmd   (next_cmd),
		.cmd        (cmd),
		.ba         (ba),
		.a          (a)
	);

endmodule

`default_nettype wire

// ==== tests/sdram_ctrl_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl_sva
	import sdram_pkg::*;
(
	input wire             CLK,
	input wire             RST,
	input wire sdram_cmd_t cmd,
	input wire             ready
);

	int         assert_fails = 0;
	sdram_cmd_t last_cmd;
	logic [4:0] idle_cnt;   // NOOP cycles since last command, saturates

	function automatic logic [4:0] min_idle(input sdram_cmd_t c);
		case (c)
			ACTV:             return 5'd2;
			READ, WRTE, PRCH: return 5'd3;
			ARSR:             return 5'd15;
			default:          return 5'd0;
		endcase
	endfunction

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			last_cmd <= NOOP;
			idle_cnt <= '0;
		end
		else if (cmd != NOOP)
		begin
			last_cmd <= cmd;
			idle_cnt <= '0;
		end
		else if (idle_cnt != 5'd31)
		begin
			idle_cnt <= idle_cnt + 5'd1;
		end
	end

	// back to back READ or WRTE of the same kind is legal
	property cmd_spacing;
		@(posedge CLK) disable iff (!RST)
		(cmd != NOOP && !((last_cmd == READ || last_cmd == WRTE) && cmd == last_cmd))
				|-> (idle_cnt >= min_idle(last_cmd));
	endproperty

	spacing_ok: assert property (cmd_spacing)
	else
	begin
		assert_fails++;
		$error("command issued before the minimum idle gap");
	end

	reset_ok: assert property (@(posedge CLK) !RST |=> (cmd == NOOP) && ready)
	else
	begin
		assert_fails++;
		$error("cmd not NOOP or ready low after reset");
	end

	// PRCH and ACTV always have a command behind them
	ready_ok: assert property (@(posedge CLK) disable iff (!RST)
			(cmd == PRCH || cmd == ACTV) |-> !ready)
	else
	begin
		assert_fails++;
		$error("ready high while commands are pending");
	end

endmodule

`default_nettype wire

// ==== tests/sdram_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_params.svh"

module sdram_ctrl_tb
	import sdram_pkg::*;
();

	localparam string GOLDEN = "tests/sdram_golden.txt";
	localparam int    WORDS  = 128;
	localparam int    MARGIN = 200;   // reset and config writes

	logic                     CLK;
	logic                     RST;
	logic                     req;
	logic [`SDRAM_ADDR_W-1:0] addr;
	logic                     we;
	logic                     cfg_wr;
	logic [`SDRAM_REF_W-1:0]  cfg_interval;
	wire                      ready;
	sdram_cmd_t               cmd;
	wire [`SDRAM_BANK_W-1:0]  ba;
	wire [`SDRAM_ROW_W-1:0]   a;

	logic [35:0]              golden [WORDS];   // kind nibble, then payload
	sdram_cmd_t               seen_cmd [$];
	logic [`SDRAM_BANK_W-1:0] seen_ba [$];
	logic [`SDRAM_ROW_W-1:0]  seen_a [$];
	sdram_cmd_t               exp_cmd [$];
	logic [`SDRAM_BANK_W-1:0] exp_ba [$];
	logic [`SDRAM_ROW_W-1:0]  exp_a [$];

	int cycles = 0;
	int limit = 0;
	int errors = 0;
	int test_errors = 0;
	int test_no = 0;
	int tests_passed = 0;
	int checks = 0;

	sdram_ctrl_top dut0 (
		.CLK          (CLK),
		.RST          (RST),
		.req          (req),
		.addr         (addr),
		.we           (we),
		.cfg_wr       (cfg_wr),
		.cfg_interval (cfg_interval),
		.ready        (ready),
		.cmd          (cmd),
		.ba           (ba),
		.a            (a)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	// every issued command, sampled mid cycle
	always @(negedge CLK)
	begin
		if (RST && cmd != NOOP)
		begin
			seen_cmd.push_back(cmd);
			seen_ba.push_back(ba);
			seen_a.push_back(a);
		end
	end

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout: run did not end within %0d cycles", limit);
			$display("sim failed");
			$finish;
		end
	end

	function automatic int run_limit();
		int n_exp;
		int idle;
		n_exp = 0;
		idle = 0;
		for (int i = 0; i < WORDS; i++)
		begin
			if (golden[i][35:32] == 4'h6)
				n_exp++;
			else if (golden[i][35:32] == 4'h5 || golden[i][35:32] == 4'h7)
				idle += int'(golden[i][31:0]);
		end
		return n_exp * 20 + idle + MARGIN;
	endfunction

	task automatic drive_config(input logic [`SDRAM_REF_W-1:0] interval);
		@(posedge CLK);
		cfg_wr       <= 1'b1;
		cfg_interval <= interval;
		@(posedge CLK);
		cfg_wr <= 1'b0;
	endtask

	task automatic send_request(input logic wr, input logic [`SDRAM_ADDR_W-1:0] adr);
		do
			@(negedge CLK);
		while (!ready);
		@(posedge CLK);
		req  <= 1'b1;
		we   <= wr;
		addr <= adr;
		do
			@(negedge CLK);   // a refresh may take the slot first
		while (!ready);
		@(posedge CLK);
		req <= 1'b0;
	endtask

	task automatic send_while_busy(input logic wr, input logic [`SDRAM_ADDR_W-1:0] adr);
		@(posedge CLK);
		req  <= 1'b1;
		we   <= wr;
		addr <= adr;
		@(negedge CLK);
		if (ready)
		begin
			$display("test %0d: request meant to be dropped found ready high at %0t",
					test_no, $time);
			test_errors++;
		end
		@(posedge CLK);
		req <= 1'b0;
	endtask

	task automatic check_cmd(input int idx, input sdram_cmd_t got, input sdram_cmd_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch at %0t: test %0d command %0d is %s, expected %s",
					$time, test_no, idx, got.name(), exp.name());
			test_errors++;
		end
	endtask

	task automatic check_pins(input int idx,
			input logic [`SDRAM_BANK_W-1:0] got_ba, input logic [`SDRAM_BANK_W-1:0] exp_ba,
			input logic [`SDRAM_ROW_W-1:0] got_a, input logic [`SDRAM_ROW_W-1:0] exp_a);
		checks++;
		if (got_ba !== exp_ba || got_a !== exp_a)
		begin
			$display("Mismatch at %0t: test %0d command %0d has ba=%0d a=%h, expected ba=%0d a=%h",
					$time, test_no, idx, got_ba, got_a, exp_ba, exp_a);
			test_errors++;
		end
	endtask

	task automatic finish_test(input int settle);
		int n;
		do
			@(negedge CLK);
		while (!ready);
		repeat (settle) @(negedge CLK);   // room for stray commands
		@(posedge CLK);
		n = (seen_cmd.size() < exp_cmd.size()) ? seen_cmd.size() : exp_cmd.size();
		if (seen_cmd.size() != exp_cmd.size())
		begin
			$display("test %0d: expected %0d commands but the DUT issued %0d",
					test_no, exp_cmd.size(), seen_cmd.size());
			test_errors++;
		end
		for (int i = 0; i < n; i++)
		begin
			check_cmd(i, seen_cmd[i], exp_cmd[i]);
			check_pins(i, seen_ba[i], exp_ba[i], seen_a[i], exp_a[i]);
		end
		$display("test %0d %s: %0d commands, %0d errors", test_no,
				(test_errors == 0) ? "done" : "FAILED", seen_cmd.size(), test_errors);
		errors += test_errors;
		if (test_errors == 0)
			tests_passed++;
		seen_cmd.delete();
		seen_ba.delete();
		seen_a.delete();
		exp_cmd.delete();
		exp_ba.delete();
		exp_a.delete();
	endtask

	initial
	begin
		logic [35:0] w;
		int          pc;
		logic        done;
		RST          = 1'b0;
		req          = 1'b0;
		addr         = '0;
		we           = 1'b0;
		cfg_wr       = 1'b0;
		cfg_interval = '0;
		done         = 1'b0;
		$readmemh(GOLDEN, golden);
		limit = run_limit();
		repeat (3) @(posedge CLK);
		RST <= 1'b1;
		for (pc = 0; pc < WORDS && !done; pc++)
		begin
			w = golden[pc];
			case (w[35:32])
				4'h1:
				begin
					test_no++;
					test_errors = 0;
					drive_config(w[15:0]);
				end
				4'h2: drive_config(w[15:0]);
				4'h3: send_request(w[28], w[27:0]);
				4'h4: send_while_busy(w[28], w[27:0]);
				4'h5: repeat (w[31:0]) @(posedge CLK);
				4'h6:
				begin
					exp_cmd.push_back(sdram_cmd_t'(w[26:24]));
					exp_ba.push_back(w[17:16]);
					exp_a.push_back(w[12:0]);
				end
				4'h7: finish_test(int'(w[31:0]));
				4'hf: done = 1'b1;
				default:
				begin
					$display("golden word %0d has no known kind", pc);
					errors++;
					done = 1'b1;
				end
			endcase
		end
		if (!done)
		begin
			$display("golden file ended without its end marker");
			errors++;
		end
		$display("%0d tests, %0d passed, %0d checks, %0d errors, %0d assertion failures",
				test_no, tests_passed, checks, errors, dut0.sva0.assert_fails);
		if (errors == 0 && dut0.sva0.assert_fails == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

bind sdram_ctrl_top sdram_ctrl_sva sva0 (
	.CLK   (CLK),
	.RST   (RST),
	.cmd   (cmd),
	.ready (ready)
);

`default_nettype wire

// ==== tests/sdram_golden.txt ====
// 36-bit words: kind digit, then 8 payload digits. kinds: 1 new test + cfg interval[15:0],
// 2 cfg write, 3 request {we[28],addr[27:0]}, 4 request while busy, 5 idle cycles,
// 6 expected {cmd[27:24],ba[19:16],a[15:0]}, 7 end of test with settle cycles, f end
// cold miss, row 123 bank 1 col 045
1_00000000
3_0091A045
6_04010000
6_01010123
6_02010045
7_00000014
// page hit write, col 100
1_00000000
3_1091A100
6_03010100
7_00000014
// conflicts, row AB bank 1 then row AB bank 2
1_00000000
3_1055A1FF
3_0055C010
6_04010000
6_010100AB
6_030101FF
6_04010000
6_010200AB
6_02020010
7_00000014
// refresh every 20 cycles, then off, then miss on the old row
1_00000014
5_0000001E
2_00000000
3_0055C020
6_04000400
6_05000000
6_04020000
6_010200AB
6_02020020
7_00000014
// refresh off over a long idle, then a hit
1_00000000
5_0000012C
3_0055C030
6_02020030
7_00000014
// miss on row CD bank 3, strobe while busy is dropped
1_00000000
3_0066E007
4_10888005
6_04020000
6_010300CD
6_02030007
7_00000014
f_00000000

// ==== sim.f ====
+incdir+include
hdl/sdram_pkg.sv
hdl/refresh_cfg.sv
hdl/bank_timer.sv
hdl/cmd_sequencer.sv
hdl/sdram_ctrl_top.sv
tests/sdram_ctrl_sva.sv
tests/sdram_ctrl_tb.sv

// ==== Makefile ====
TOP := sdram_ctrl_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -Wno-fatal -f sim.f --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
